// File: Makefile
BIN  := obj_dir/Vboard_top_tb
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "Testbench passed" sim.log

$(BIN): sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module board_top_tb -f sources.f -o Vboard_top_tb

clean:
	rm -rf obj_dir sim.log

// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    ////////////////////////////////////////
    // External SRAM and machine addresses
    ////////////////////////////////////////

    // Full SRAM address bus on the board
    typedef logic [20:0] sram_addr_t;
    // Address range the machine can reach
    typedef logic [18:0] machine_addr_t;
    // Byte read back from SRAM
    typedef logic [7:0]  cfg_byte_t;

    // Configuration byte location in SRAM
    localparam sram_addr_t BOOT_CFG_ADDR = 21'h008FD5;

    ////////////////////////////////////////
    // Boot timing
    ////////////////////////////////////////

    // Cycles the machine is held in reset after release
    localparam int BOOT_CYCLES = 8;

    typedef logic [$clog2(BOOT_CYCLES)-1:0] boot_cnt_t;
    // Count value of the final boot cycle
    localparam boot_cnt_t BOOT_CNT_LAST = boot_cnt_t'(BOOT_CYCLES - 1);

    // Bit positions in the configuration byte
    localparam int CFG_SCAN_BIT  = 0;
    localparam int CFG_BLANK_BIT = 1;

    // Video modes captured at boot
    typedef struct packed {
        logic scan_effect;
        logic sync_blank;
    } boot_cfg_t;

endpackage

`default_nettype wire

// File: design/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top (
    input  wire                           clk6,
    input  wire                           rst_n,
    input  wire board_pkg::cfg_byte_t     sram_rdata,
    input  wire board_pkg::machine_addr_t machine_sram_addr,
    input  wire                           machine_sram_we_n,
    input  wire video_pkg::colour_level_t pix_r,
    input  wire video_pkg::colour_level_t pix_g,
    input  wire video_pkg::colour_level_t pix_b,
    input  wire                           pix_bright,
    input  wire                           pal_hsync_n,
    input  wire                           pal_vsync_n,
    output board_pkg::sram_addr_t         sram_addr,
    output logic                          sram_we_n,
    output logic                          machine_reset_n,
    output video_pkg::colour_out_t        r,
    output video_pkg::colour_out_t        g,
    output video_pkg::colour_out_t        b,
    output logic                          hsync_n,
    output logic                          vsync_n
);

    board_pkg::boot_cfg_t   boot_cfg;
    video_pkg::channel_in_t chan [video_pkg::NUM_CHANNELS];
    video_pkg::sync_t       sync;
    video_pkg::colour_out_t levels [video_pkg::NUM_CHANNELS];

    ////////////////////////////////////////
    // Boot and SRAM hand-over
    ////////////////////////////////////////

    boot_sequencer u_boot_sequencer (
        .clk6              (clk6),
        .rst_n             (rst_n),
        .sram_rdata        (sram_rdata),
        .machine_sram_addr (machine_sram_addr),
        .machine_sram_we_n (machine_sram_we_n),
        .sram_addr         (sram_addr),
        .sram_we_n         (sram_we_n),
        .machine_reset_n   (machine_reset_n),
        .boot_cfg          (boot_cfg)
    );

    ////////////////////////////////////////
    // Video pipeline
    ////////////////////////////////////////

    video_input_stage u_video_input_stage (
        .clk6            (clk6),
        .machine_reset_n (machine_reset_n),
        .pix_r           (pix_r),
        .pix_g           (pix_g),
        .pix_b           (pix_b),
        .pix_bright      (pix_bright),
        .pal_hsync_n     (pal_hsync_n),
        .pal_vsync_n     (pal_vsync_n),
        .chan            (chan),
        .sync            (sync)
    );

    // One channel per colour, same scanline mode on all
    for (genvar k = 0; k < video_pkg::NUM_CHANNELS; k++) begin : g_channel
        colour_channel u_colour_channel (
            .clk6            (clk6),
            .machine_reset_n (machine_reset_n),
            .chan            (chan[k]),
            .scan_effect     (boot_cfg.scan_effect),
            .level           (levels[k])
        );
    end

    video_output_stage u_video_output_stage (
        .clk6            (clk6),
        .machine_reset_n (machine_reset_n),
        .levels          (levels),
        .sync            (sync),
        .sync_blank      (boot_cfg.sync_blank),
        .r               (r),
        .g               (g),
        .b               (b),
        .hsync_n         (hsync_n),
        .vsync_n         (vsync_n)
    );

endmodule

`default_nettype wire

// File: design/boot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer (
    input  wire                        clk6,
    input  wire                        rst_n,
    input  wire board_pkg::cfg_byte_t  sram_rdata,
    input  wire board_pkg::machine_addr_t machine_sram_addr,
    input  wire                        machine_sram_we_n,
    output board_pkg::sram_addr_t      sram_addr,
    output logic                       sram_we_n,
    output logic                       machine_reset_n,
    output board_pkg::boot_cfg_t       boot_cfg
);

    // Wait while rst_n low, boot for a fixed count, then run
    typedef enum logic [1:0] {
        ST_WAIT,
        ST_BOOT,
        ST_RUN
    } boot_state_t;

    boot_state_t          state;
    board_pkg::boot_cnt_t boot_cnt;

    ////////////////////////////////////////
    // Power-on state machine
    ////////////////////////////////////////

    always_ff @(posedge clk6) begin
        if (!rst_n) begin
            state    <= ST_WAIT;
            boot_cnt <= '0;
            boot_cfg <= '0;
        end else begin
            case (state)
                // First edge with rst_n high
                ST_WAIT: begin
                    state    <= ST_BOOT;
                    boot_cnt <= '0;
                end
                ST_BOOT: begin
                    if (boot_cnt == board_pkg::BOOT_CNT_LAST) begin
                        // SRAM parked on config byte, sample it now
                        boot_cfg.scan_effect <= sram_rdata[board_pkg::CFG_SCAN_BIT];
                        boot_cfg.sync_blank  <= sram_rdata[board_pkg::CFG_BLANK_BIT];
                        state                <= ST_RUN;
                    end else begin
                        boot_cnt <= boot_cnt + 1'b1;
                    end
                end
                // Config holds until next rst_n
                ST_RUN: state <= ST_RUN;
                default: state <= ST_WAIT;
            endcase
        end
    end

    ////////////////////////////////////////
    // SRAM ownership
    ////////////////////////////////////////

    // Machine only out of reset once running
    assign machine_reset_n = (state == ST_RUN);

    // Boot address and no writes until the machine owns the bus
    assign sram_addr = machine_reset_n ? board_pkg::sram_addr_t'(machine_sram_addr)
                                       : board_pkg::BOOT_CFG_ADDR;
    assign sram_we_n = machine_reset_n ? machine_sram_we_n : 1'b1;

endmodule

`default_nettype wire

// File: design/colour_channel.sv
`timescale 1ns/1ps
`default_nettype none

module colour_channel (
    input  wire                         clk6,
    input  wire                         machine_reset_n,
    input  wire video_pkg::channel_in_t chan,
    input  wire                         scan_effect,
    output video_pkg::colour_out_t      level
);

    // Level in the top bits, bright as LSB
    video_pkg::colour_out_t full_level;
    // Half intensity for scanlines
    video_pkg::colour_out_t dim_level;
    logic                   dim_en;

    assign full_level = {chan.level, chan.bright};
    assign dim_level  = full_level >> 1;

    // Only odd lines are dimmed
    assign dim_en = scan_effect & chan.odd_line;

    ////////////////////////////////////////
    // Stage two register
    ////////////////////////////////////////

    always_ff @(posedge clk6) begin
        if (!machine_reset_n) begin
            level <= '0;
        end else if (dim_en) begin
            level <= dim_level;
        end else begin
            level <= full_level;
        end
    end

endmodule

`default_nettype wire

// File: design/video_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

module video_input_stage (
    input  wire                           clk6,
    input  wire                           machine_reset_n,
    input  wire video_pkg::colour_level_t pix_r,
    input  wire video_pkg::colour_level_t pix_g,
    input  wire video_pkg::colour_level_t pix_b,
    input  wire                           pix_bright,
    input  wire                           pal_hsync_n,
    input  wire                           pal_vsync_n,
    output video_pkg::channel_in_t        chan [video_pkg::NUM_CHANNELS],
    output video_pkg::sync_t              sync
);

    // Incoming levels in channel index order
    video_pkg::colour_level_t pix_level [video_pkg::NUM_CHANNELS];

    // Stage one registers
    video_pkg::colour_level_t level_q [video_pkg::NUM_CHANNELS];
    logic                     bright_q;
    logic                     odd_line_q;
    video_pkg::sync_t         sync_q;

    // Falling hsync against last registered value
    logic hsync_fall;

    assign pix_level[video_pkg::CH_RED]   = pix_r;
    assign pix_level[video_pkg::CH_GREEN] = pix_g;
    assign pix_level[video_pkg::CH_BLUE]  = pix_b;

    assign hsync_fall = sync_q.hsync_n & ~pal_hsync_n;

    ////////////////////////////////////////
    // Input registers and line parity
    ////////////////////////////////////////

    always_ff @(posedge clk6) begin
        if (!machine_reset_n) begin
            level_q    <= '{default: '0};
            bright_q   <= 1'b0;
            // Even line after reset
            odd_line_q <= 1'b0;
            sync_q     <= video_pkg::SYNC_IDLE;
        end else begin
            level_q    <= pix_level;
            bright_q   <= pix_bright;
            // Pixel on the falling edge already belongs to the new line
            odd_line_q <= odd_line_q ^ hsync_fall;
            sync_q     <= '{hsync_n: pal_hsync_n, vsync_n: pal_vsync_n};
        end
    end

    // Bright and parity shared by all channels
    always_comb begin
        for (int k = 0; k < video_pkg::NUM_CHANNELS; k++) begin
            chan[k] = '{level: level_q[k], bright: bright_q, odd_line: odd_line_q};
        end
    end

    assign sync = sync_q;

endmodule

`default_nettype wire

// File: design/video_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module video_output_stage (
    input  wire                         clk6,
    input  wire                         machine_reset_n,
    input  wire video_pkg::colour_out_t levels [video_pkg::NUM_CHANNELS],
    input  wire video_pkg::sync_t       sync,
    input  wire                         sync_blank,
    output video_pkg::colour_out_t      r,
    output video_pkg::colour_out_t      g,
    output video_pkg::colour_out_t      b,
    output logic                        hsync_n,
    output logic                        vsync_n
);

    // Sync aligned with channel registers
    video_pkg::sync_t sync_d;
    logic             blank;

    // Either sync active
    assign blank = sync_blank & ~(sync_d.hsync_n & sync_d.vsync_n);

    ////////////////////////////////////////
    // Sync delay, stage two
    ////////////////////////////////////////

    always_ff @(posedge clk6) begin
        if (!machine_reset_n) begin
            sync_d <= video_pkg::SYNC_IDLE;
        end else begin
            sync_d <= sync;
        end
    end

    ////////////////////////////////////////
    // Output registers, stage three
    ////////////////////////////////////////

    always_ff @(posedge clk6) begin
        if (!machine_reset_n) begin
            // Black with syncs idle while machine held
            r       <= '0;
            g       <= '0;
            b       <= '0;
            hsync_n <= 1'b1;
            vsync_n <= 1'b1;
        end else begin
            r       <= blank ? '0 : levels[video_pkg::CH_RED];
            g       <= blank ? '0 : levels[video_pkg::CH_GREEN];
            b       <= blank ? '0 : levels[video_pkg::CH_BLUE];
            hsync_n <= sync_d.hsync_n;
            vsync_n <= sync_d.vsync_n;
        end
    end

endmodule

`default_nettype wire

// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

    ////////////////////////////////////////
    // Colour widths
    ////////////////////////////////////////

    // Machine level for one channel
    typedef logic [1:0] colour_level_t;
    // Expanded level on the board DAC
    typedef logic [2:0] colour_out_t;

    ////////////////////////////////////////
    // Channel layout and timing
    ////////////////////////////////////////

    // Red, green and blue
    localparam int NUM_CHANNELS = 3;

    // Channel index order
    localparam int CH_RED   = 0;
    localparam int CH_GREEN = 1;
    localparam int CH_BLUE  = 2;

    // Input to output delay in clk6 cycles
    localparam int VIDEO_LATENCY = 3;

    ////////////////////////////////////////
    // Pipeline structs
    ////////////////////////////////////////

    // One channel as it leaves the input stage
    typedef struct packed {
        colour_level_t level;
        logic          bright;
        logic          odd_line;
    } channel_in_t;

    // Both syncs, active low
    typedef struct packed {
        logic hsync_n;
        logic vsync_n;
    } sync_t;

    // Syncs inactive
    localparam sync_t SYNC_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1};

endpackage

`default_nettype wire

// File: sources.f
design/board_pkg.sv
design/video_pkg.sv
design/boot_sequencer.sv
design/video_input_stage.sv
design/colour_channel.sv
design/video_output_stage.sv
design/board_top.sv
verification/board_top_tb.sv

// File: verification/board_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;

    // Stimulus shape and run length
    localparam int RESET_CYCLES   = 8;
    localparam int PASS_PIXELS    = 400;
    localparam int LINE_PIXELS    = 40;
    localparam int HSYNC_START    = 32;
    localparam int HSYNC_END      = 36;
    localparam int PASS_CYCLES    = RESET_CYCLES + board_pkg::BOOT_CYCLES + 1 + PASS_PIXELS;
    localparam int TIMEOUT_CYCLES = 4 * PASS_CYCLES + 60;

    // Predicted output for one pixel and whether it survives the pipeline clear
    typedef struct packed {
        logic                   live;
        video_pkg::colour_out_t r;
        video_pkg::colour_out_t g;
        video_pkg::colour_out_t b;
        logic                   hsync_n;
        logic                   vsync_n;
    } expect_t;

    logic                     clk6;
    logic                     rst_n;
    board_pkg::cfg_byte_t     sram_rdata;
    board_pkg::machine_addr_t machine_sram_addr;
    logic                     machine_sram_we_n;
    video_pkg::colour_level_t pix_r;
    video_pkg::colour_level_t pix_g;
    video_pkg::colour_level_t pix_b;
    logic                     pix_bright;
    logic                     pal_hsync_n;
    logic                     pal_vsync_n;
    board_pkg::sram_addr_t    sram_addr;
    logic                     sram_we_n;
    logic                     machine_reset_n;
    video_pkg::colour_out_t   r;
    video_pkg::colour_out_t   g;
    video_pkg::colour_out_t   b;
    logic                     hsync_n;
    logic                     vsync_n;

    // Model state
    logic [31:0]          rng = 32'hd160_2853;
    int                   cycle_cnt = 0;
    int                   rel_cnt = 0;
    int                   line_px = 0;
    int                   line_no = 0;
    logic                 odd_line = 1'b0;
    logic                 prev_hsync_n = 1'b1;
    logic                 armed;
    board_pkg::boot_cfg_t cfg_model = '0;
    expect_t              hist [3] = '{default: '0};

    board_top dut (.*);

    initial begin
        clk6 = 1'b0;
        forever #50 clk6 = ~clk6;
    end

    // Skip the first edges while the DUT registers settle
    assign armed = cycle_cnt >= 4;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic video_pkg::colour_out_t expected_level(
        input video_pkg::colour_level_t level, input logic bright, input logic dim);
        video_pkg::colour_out_t v;
        v = {level, bright};
        if (dim) v = v >> 1;
        return v;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else
            stop_on_error($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, want));
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One clock of inputs with the low config bits from the caller
    task automatic drive_cycle(input logic rst, input logic [1:0] cfg_bits);
        logic [31:0] rnd;
        rng = xorshift32(rng);
        rnd = rng;
        @(posedge clk6);
        rst_n             <= rst;
        sram_rdata        <= {rnd[31:26], cfg_bits};
        machine_sram_addr <= rnd[18:0];
        machine_sram_we_n <= rnd[19];
        pix_r             <= rnd[21:20];
        pix_g             <= rnd[23:22];
        pix_b             <= rnd[25:24];
        pix_bright        <= rnd[26];
        // Short synthetic line with vsync on every sixth line
        pal_hsync_n       <= !(line_px >= HSYNC_START && line_px < HSYNC_END);
        pal_vsync_n       <= (line_no % 6) != 5;
        line_px = (line_px + 1) % LINE_PIXELS;
        if (line_px == 0) line_no++;
    endtask

    // Wrong mode bits on every cycle except the capture cycle
    task automatic run_pass(input logic [1:0] mode);
        cfg_model.scan_effect = mode[0];
        cfg_model.sync_blank  = mode[1];
        for (int i = 0; i < RESET_CYCLES; i++) drive_cycle(1'b0, ~mode);
        for (int i = 0; i < board_pkg::BOOT_CYCLES + 1 + PASS_PIXELS; i++) begin
            drive_cycle(1'b1, (i == board_pkg::BOOT_CYCLES) ? mode : ~mode);
        end
    endtask

    initial begin
        rst_n             = 1'b0;
        sram_rdata        = '0;
        machine_sram_addr = '0;
        machine_sram_we_n = 1'b1;
        pix_r             = '0;
        pix_g             = '0;
        pix_b             = '0;
        pix_bright        = 1'b0;
        pal_hsync_n       = 1'b1;
        pal_vsync_n       = 1'b1;
        for (int m = 0; m < 4; m++) run_pass(2'(m));
        repeat (video_pkg::VIDEO_LATENCY + 2) @(posedge clk6);
        $display("Testbench passed");
        $finish;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    always @(posedge clk6) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) stop_on_error("Timeout: run did not finish in time");
    end

    // Machine released a fixed number of edges after rst_n rises
    boot_release: assert property (@(posedge clk6) disable iff (!armed)
        $rose(machine_reset_n) |->
            ($past(rst_n, board_pkg::BOOT_CYCLES + 1)
             && !$past(rst_n, board_pkg::BOOT_CYCLES + 2)))
        else stop_on_error("machine_reset_n released at the wrong time after rst_n");

    always @(negedge clk6) begin : check_outputs
        expect_t cur;
        expect_t want;
        logic    exp_run;
        // Machine runs once rst_n seen high on more than BOOT_CYCLES edges
        exp_run = rel_cnt > board_pkg::BOOT_CYCLES;
        want    = '{live: 1'b1, r: '0, g: '0, b: '0, hsync_n: 1'b1, vsync_n: 1'b1};
        if (hist[0].live && hist[1].live && hist[2].live) want = hist[2];
        if (armed) begin
            check_value("machine_reset_n", 32'(machine_reset_n), 32'(exp_run));
            check_value("sram_addr", 32'(sram_addr),
                        exp_run ? 32'(machine_sram_addr) : 32'(board_pkg::BOOT_CFG_ADDR));
            check_value("sram_we_n", 32'(sram_we_n), exp_run ? 32'(machine_sram_we_n) : 32'd1);
            check_value("r", 32'(r), 32'(want.r));
            check_value("g", 32'(g), 32'(want.g));
            check_value("b", 32'(b), 32'(want.b));
            check_value("hsync_n", 32'(hsync_n), 32'(want.hsync_n));
            check_value("vsync_n", 32'(vsync_n), 32'(want.vsync_n));
        end
        // Line parity from falling hsync edges starting even after reset
        if (!exp_run) begin
            odd_line     = 1'b0;
            prev_hsync_n = 1'b1;
        end else begin
            if (prev_hsync_n && !pal_hsync_n) odd_line = ~odd_line;
            prev_hsync_n = pal_hsync_n;
        end
        cur.live    = exp_run;
        cur.r       = expected_level(pix_r, pix_bright, cfg_model.scan_effect && odd_line);
        cur.g       = expected_level(pix_g, pix_bright, cfg_model.scan_effect && odd_line);
        cur.b       = expected_level(pix_b, pix_bright, cfg_model.scan_effect && odd_line);
        cur.hsync_n = pal_hsync_n;
        cur.vsync_n = pal_vsync_n;
        if (cfg_model.sync_blank && !(pal_hsync_n && pal_vsync_n)) begin
            cur.r = '0;
            cur.g = '0;
            cur.b = '0;
        end
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = cur;
        if (!rst_n) rel_cnt = 0;
        else if (rel_cnt <= board_pkg::BOOT_CYCLES) rel_cnt++;
    end

endmodule

`default_nettype wire
